// File: hdl/isaPkg.sv
package isaPkg;

    localparam int opWidth   = 6;
    localparam int funcWidth = 6;

    // opcodes handled by the unit
    localparam logic [opWidth-1:0] opRType = 6'h00;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opAddiu = 6'h09;

    // R-type funct codes
    localparam logic [funcWidth-1:0] fnSll   = 6'h00;
    localparam logic [funcWidth-1:0] fnSrl   = 6'h02;
    localparam logic [funcWidth-1:0] fnSra   = 6'h03;
    localparam logic [funcWidth-1:0] fnSllv  = 6'h04;
    localparam logic [funcWidth-1:0] fnSrav  = 6'h07;
    localparam logic [funcWidth-1:0] fnJr    = 6'h08;
    localparam logic [funcWidth-1:0] fnBreak = 6'h0d;
    localparam logic [funcWidth-1:0] fnMfhi  = 6'h10;
    localparam logic [funcWidth-1:0] fnMflo  = 6'h12;
    localparam logic [funcWidth-1:0] fnAdd   = 6'h20;
    localparam logic [funcWidth-1:0] fnSub   = 6'h22;
    localparam logic [funcWidth-1:0] fnAnd   = 6'h24;
    localparam logic [funcWidth-1:0] fnSlt   = 6'h2a;

    // the two instruction fields the control unit looks at
    typedef struct packed {
        logic [opWidth-1:0]   opcode;   // bits 31:26 of the instruction
        logic [funcWidth-1:0] funct;    // bits 5:0 of an R-type instruction
    } instrFields_t;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

    localparam int stateWidth = 6;

    localparam logic [stateWidth-1:0] stFetch          = 6'd0;
    localparam logic [stateWidth-1:0] stFetch2         = 6'd1;
    localparam logic [stateWidth-1:0] stMemWait        = 6'd2;
    localparam logic [stateWidth-1:0] stDecode         = 6'd3;
    localparam logic [stateWidth-1:0] stDispatch       = 6'd4;
    localparam logic [stateWidth-1:0] stAdd            = 6'd5;
    localparam logic [stateWidth-1:0] stSub            = 6'd6;
    localparam logic [stateWidth-1:0] stAnd            = 6'd7;
    localparam logic [stateWidth-1:0] stAluWriteBack   = 6'd8;
    localparam logic [stateWidth-1:0] stAddi           = 6'd9;
    localparam logic [stateWidth-1:0] stAddiu          = 6'd10;
    localparam logic [stateWidth-1:0] stImmWriteBack   = 6'd11;
    localparam logic [stateWidth-1:0] stSlt            = 6'd12;
    localparam logic [stateWidth-1:0] stSll            = 6'd13;
    localparam logic [stateWidth-1:0] stSrl            = 6'd14;
    localparam logic [stateWidth-1:0] stSra            = 6'd15;
    localparam logic [stateWidth-1:0] stSllv           = 6'd16;
    localparam logic [stateWidth-1:0] stSrav           = 6'd17;
    localparam logic [stateWidth-1:0] stShiftWriteBack = 6'd18;
    localparam logic [stateWidth-1:0] stMfhi           = 6'd19;
    localparam logic [stateWidth-1:0] stMflo           = 6'd20;
    localparam logic [stateWidth-1:0] stJr             = 6'd21;
    localparam logic [stateWidth-1:0] stBreak          = 6'd22;
    localparam logic [stateWidth-1:0] stTrap           = 6'd23;
    localparam logic [stateWidth-1:0] stFinish         = 6'd24;

    // field widths of the control word
    localparam int pcSourceWidth   = 3;
    localparam int regDestWidth    = 2;
    localparam int dataSourceWidth = 4;
    localparam int aluSrcWidth     = 2;
    localparam int aluOpWidth      = 3;
    localparam int shiftOpWidth    = 3;
    localparam int excptWidth      = 2;

    localparam logic [aluOpWidth-1:0] aluPass = 3'd0;
    localparam logic [aluOpWidth-1:0] aluAdd  = 3'd1;
    localparam logic [aluOpWidth-1:0] aluSub  = 3'd2;
    localparam logic [aluOpWidth-1:0] aluAnd  = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt  = 3'd7;

    localparam logic [aluSrcWidth-1:0] srcAPc     = 2'd0;
    localparam logic [aluSrcWidth-1:0] srcARegA   = 2'd1;
    localparam logic [aluSrcWidth-1:0] srcBRegB   = 2'd0;
    localparam logic [aluSrcWidth-1:0] srcBFour   = 2'd1;
    localparam logic [aluSrcWidth-1:0] srcBImm    = 2'd2;
    localparam logic [aluSrcWidth-1:0] srcBOffset = 2'd3;   // sign-extended, shifted imm

    localparam logic [pcSourceWidth-1:0] pcFromAlu  = 3'd0;
    localparam logic [pcSourceWidth-1:0] pcFromTrap = 3'd4;

    localparam logic [dataSourceWidth-1:0] dsAluOut    = 4'd0;
    localparam logic [dataSourceWidth-1:0] dsLo        = 4'd2;
    localparam logic [dataSourceWidth-1:0] dsHi        = 4'd3;
    localparam logic [dataSourceWidth-1:0] dsShift     = 4'd4;
    localparam logic [dataSourceWidth-1:0] dsLessThan  = 4'd5;
    localparam logic [dataSourceWidth-1:0] dsStackInit = 4'd10;   // constant 227

    localparam logic [regDestWidth-1:0] dstRt = 2'd0;
    localparam logic [regDestWidth-1:0] dstRd = 2'd1;
    localparam logic [regDestWidth-1:0] dstSp = 2'd3;   // $29

    localparam logic [shiftOpWidth-1:0] shNone       = 3'd0;
    localparam logic [shiftOpWidth-1:0] shLeft       = 3'd2;
    localparam logic [shiftOpWidth-1:0] shRightLogic = 3'd3;
    localparam logic [shiftOpWidth-1:0] shRightArith = 3'd4;

    localparam logic [excptWidth-1:0] excNone    = 2'd0;
    localparam logic [excptWidth-1:0] excIllegal = 2'd1;

    typedef struct packed {
        logic                       pcWrite;
        logic [pcSourceWidth-1:0]   pcSource;
        logic                       irWrite;
        logic                       regWrite;
        logic [regDestWidth-1:0]    regDest;
        logic [dataSourceWidth-1:0] dataSource;
        logic                       aWrite;
        logic                       bWrite;
        logic                       aluOutWrite;
        logic [aluSrcWidth-1:0]     aluSrcA;
        logic [aluSrcWidth-1:0]     aluSrcB;
        logic [aluOpWidth-1:0]      aluOp;
        logic                       shiftSource;      // 1 = rt, 0 = rs
        logic                       shiftAmtSource;   // 1 = shamt field, 0 = register
        logic [shiftOpWidth-1:0]    shiftOp;
        logic                       epcWrite;
        logic [excptWidth-1:0]      excptSelect;
    } ctrlWord_t;

    localparam ctrlWord_t ctrlIdle = '0;

endpackage

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  instrFields_t          instr,
    output logic [stateWidth-1:0] execState
);

    always_comb begin
        execState = stTrap;   // anything unknown traps
        case (instr.opcode)
            opRType: begin
                case (instr.funct)
                    fnAdd: begin
                        execState = stAdd;
                    end
                    fnSub: begin
                        execState = stSub;
                    end
                    fnAnd: begin
                        execState = stAnd;
                    end
                    fnSlt: begin
                        execState = stSlt;
                    end
                    fnSll: begin
                        execState = stSll;
                    end
                    fnSrl: begin
                        execState = stSrl;
                    end
                    fnSra: begin
                        execState = stSra;
                    end
                    fnSllv: begin
                        execState = stSllv;
                    end
                    fnSrav: begin
                        execState = stSrav;
                    end
                    fnMfhi: begin
                        execState = stMfhi;
                    end
                    fnMflo: begin
                        execState = stMflo;
                    end
                    fnJr: begin
                        execState = stJr;
                    end
                    fnBreak: begin
                        execState = stBreak;
                    end
                    default: begin
                        execState = stTrap;
                    end
                endcase
            end
            opAddi: begin
                execState = stAddi;
            end
            opAddiu: begin
                execState = stAddiu;
            end
            default: begin
                execState = stTrap;
            end
        endcase
    end

endmodule

// File: hdl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer
    import ctrlPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [stateWidth-1:0] execState,
    output logic [stateWidth-1:0] state,
    output logic [stateWidth-1:0] nextState
);

    logic resetDone;   // low for the first cycle out of reset

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= stFetch;
            resetDone <= 1'b0;
        end else begin
            state     <= nextState;
            resetDone <= 1'b1;
        end
    end

    always_comb begin
        nextState = stFetch;
        case (state)
            // hold one extra cycle so the stack-init word gets its own cycle
            stFetch: begin
                nextState = resetDone ? stFetch2 : stFetch;
            end
            stFetch2: begin
                nextState = stMemWait;
            end
            stMemWait: begin
                nextState = stDecode;
            end
            stDecode: begin
                nextState = stDispatch;
            end
            stDispatch: begin
                nextState = execState;
            end
            stAdd, stSub, stAnd: begin
                nextState = stAluWriteBack;
            end
            stAddi, stAddiu: begin
                nextState = stImmWriteBack;
            end
            stSll, stSrl, stSra, stSllv, stSrav: begin
                nextState = stShiftWriteBack;
            end
            stAluWriteBack, stImmWriteBack, stShiftWriteBack: begin
                nextState = stFinish;
            end
            stSlt, stMfhi, stMflo, stJr, stBreak, stTrap: begin
                nextState = stFinish;   // single-cycle execution
            end
            stFinish: begin
                nextState = stFetch;
            end
            default: begin
                nextState = stFetch;
            end
        endcase
    end

endmodule

// File: hdl/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen
    import ctrlPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [stateWidth-1:0] nextState,
    output ctrlWord_t             ctrl
);

    ctrlWord_t stateWord;
    ctrlWord_t stackWord;

    // writes the initial stack pointer into $29
    always_comb begin
        stackWord            = ctrlIdle;
        stackWord.regWrite   = 1'b1;
        stackWord.regDest    = dstSp;
        stackWord.dataSource = dsStackInit;
    end

    always_comb begin
        stateWord = ctrlIdle;
        case (nextState)
            stFetch: begin
                stateWord.pcWrite = 1'b1;   // pc + 4
                stateWord.aluSrcA = srcAPc;
                stateWord.aluSrcB = srcBFour;
                stateWord.aluOp   = aluAdd;
            end
            stFetch2: begin
                stateWord.pcWrite = 1'b1;
            end
            stMemWait: begin
                stateWord.irWrite = 1'b1;
            end
            stDecode: begin
                stateWord.aWrite      = 1'b1;
                stateWord.bWrite      = 1'b1;
                stateWord.aluOutWrite = 1'b1;   // speculative branch target
                stateWord.aluSrcA     = srcAPc;
                stateWord.aluSrcB     = srcBOffset;
                stateWord.aluOp       = aluAdd;
            end
            stAdd, stSub, stAnd: begin
                stateWord.aluOutWrite = 1'b1;
                stateWord.aluSrcA     = srcARegA;
                stateWord.aluSrcB     = srcBRegB;
                if (nextState == stAdd) begin
                    stateWord.aluOp = aluAdd;
                end else if (nextState == stSub) begin
                    stateWord.aluOp = aluSub;
                end else begin
                    stateWord.aluOp = aluAnd;
                end
            end
            stAluWriteBack: begin
                stateWord.regWrite   = 1'b1;
                stateWord.regDest    = dstRd;
                stateWord.dataSource = dsAluOut;
            end
            stAddi, stAddiu: begin
                stateWord.aluOutWrite = 1'b1;
                stateWord.aluSrcA     = srcARegA;
                stateWord.aluSrcB     = srcBImm;
                stateWord.aluOp       = aluAdd;
            end
            stImmWriteBack: begin
                stateWord.regWrite   = 1'b1;
                stateWord.regDest    = dstRt;
                stateWord.dataSource = dsAluOut;
            end
            stSll, stSrl, stSra: begin
                stateWord.shiftSource    = 1'b1;
                stateWord.shiftAmtSource = 1'b1;   // shamt field
                if (nextState == stSll) begin
                    stateWord.shiftOp = shLeft;
                end else if (nextState == stSrl) begin
                    stateWord.shiftOp = shRightLogic;
                end else begin
                    stateWord.shiftOp = shRightArith;
                end
            end
            stSllv, stSrav: begin
                stateWord.shiftSource    = 1'b0;
                stateWord.shiftAmtSource = 1'b0;   // amount from rs
                stateWord.shiftOp = (nextState == stSllv) ? shLeft : shRightArith;
            end
            stShiftWriteBack: begin
                stateWord.regWrite   = 1'b1;
                stateWord.regDest    = dstRd;
                stateWord.dataSource = dsShift;
            end
            stSlt: begin
                stateWord.regWrite   = 1'b1;
                stateWord.regDest    = dstRd;
                stateWord.dataSource = dsLessThan;
                stateWord.aluSrcA    = srcARegA;
                stateWord.aluSrcB    = srcBRegB;
                stateWord.aluOp      = aluSlt;
            end
            stMfhi, stMflo: begin
                stateWord.regWrite   = 1'b1;
                stateWord.regDest    = dstRd;
                stateWord.dataSource = (nextState == stMfhi) ? dsHi : dsLo;
            end
            stJr: begin
                stateWord.pcWrite  = 1'b1;
                stateWord.pcSource = pcFromAlu;
                stateWord.aluSrcA  = srcARegA;
                stateWord.aluOp    = aluPass;
            end
            stBreak: begin
                stateWord.pcWrite  = 1'b1;   // pc - 4 lands back on the break
                stateWord.pcSource = pcFromAlu;
                stateWord.aluSrcA  = srcAPc;
                stateWord.aluSrcB  = srcBFour;
                stateWord.aluOp    = aluSub;
            end
            stTrap: begin
                stateWord.pcWrite     = 1'b1;
                stateWord.pcSource    = pcFromTrap;
                stateWord.epcWrite    = 1'b1;
                stateWord.excptSelect = excIllegal;
            end
            default: begin
                stateWord = ctrlIdle;   // dispatch, finish
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= stackWord;
        end else begin
            ctrl <= stateWord;
        end
    end

endmodule

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instrFields_t instr,
    output ctrlWord_t    ctrl
);

    logic [stateWidth-1:0] execState;
    logic [stateWidth-1:0] nextState;

    instrDecoder decoder (
        .instr     (instr),
        .execState (execState)
    );

    controlSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .execState (execState),
        .state     (),
        .nextState (nextState)
    );

    controlWordGen wordGen (
        .clk       (clk),
        .reset     (reset),
        .nextState (nextState),
        .ctrl      (ctrl)
    );

endmodule

// File: testbench/controlUnit_checker.sv
`timescale 1ns/1ps

module controlUnitChecker
    import ctrlPkg::*;
(
    input logic      clk,
    input logic      reset,
    input ctrlWord_t ctrl
);

    // instruction load never shares a cycle with a register or pc update
    irWriteAlone: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |-> !(ctrl.regWrite || ctrl.pcWrite))
        else $error("irWrite together with regWrite or pcWrite");

    epcOnlyOnTrap: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> (ctrl.excptSelect == excIllegal && ctrl.pcSource == pcFromTrap))
        else $error("epcWrite without trap select");

    irWriteSingle: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |=> !ctrl.irWrite)
        else $error("irWrite held for two cycles");

endmodule

// File: testbench/controlModel.svh
function automatic ctrlWord_t stackInitWord();
    ctrlWord_t w;
    w            = ctrlIdle;
    w.regWrite   = 1'b1;
    w.regDest    = dstSp;
    w.dataSource = dsStackInit;
    return w;
endfunction

function automatic logic isRType(instrFields_t i, logic [funcWidth-1:0] fn);
    return (i.opcode == opRType) && (i.funct == fn);
endfunction

// cycles per instruction
function automatic int modelLength(instrFields_t i);
    if (isRType(i, fnAdd) || isRType(i, fnSub) || isRType(i, fnAnd)) begin
        return 8;
    end
    if (i.opcode == opAddi || i.opcode == opAddiu) begin
        return 8;
    end
    if (isRType(i, fnSll) || isRType(i, fnSrl) || isRType(i, fnSra)) begin
        return 8;
    end
    if (isRType(i, fnSllv) || isRType(i, fnSrav)) begin
        return 8;
    end
    return 7;   // slt, mfhi, mflo, jr, break, trap
endfunction

function automatic ctrlWord_t execWord(instrFields_t i);
    ctrlWord_t w;
    w = ctrlIdle;
    if (isRType(i, fnAdd) || isRType(i, fnSub) || isRType(i, fnAnd)) begin
        w.aluOutWrite = 1'b1;
        w.aluSrcA     = srcARegA;
        w.aluSrcB     = srcBRegB;
        w.aluOp       = isRType(i, fnAdd) ? aluAdd : (isRType(i, fnSub) ? aluSub : aluAnd);
    end else if (i.opcode == opAddi || i.opcode == opAddiu) begin
        w.aluOutWrite = 1'b1;
        w.aluSrcA     = srcARegA;
        w.aluSrcB     = srcBImm;
        w.aluOp       = aluAdd;
    end else if (isRType(i, fnSll) || isRType(i, fnSrl) || isRType(i, fnSra)) begin
        w.shiftSource    = 1'b1;
        w.shiftAmtSource = 1'b1;
        w.shiftOp = isRType(i, fnSll) ? shLeft : (isRType(i, fnSrl) ? shRightLogic : shRightArith);
    end else if (isRType(i, fnSllv) || isRType(i, fnSrav)) begin
        w.shiftOp = isRType(i, fnSllv) ? shLeft : shRightArith;
    end else if (isRType(i, fnSlt)) begin
        w.regWrite   = 1'b1;
        w.regDest    = dstRd;
        w.dataSource = dsLessThan;
        w.aluSrcA    = srcARegA;
        w.aluSrcB    = srcBRegB;
        w.aluOp      = aluSlt;
    end else if (isRType(i, fnMfhi) || isRType(i, fnMflo)) begin
        w.regWrite   = 1'b1;
        w.regDest    = dstRd;
        w.dataSource = isRType(i, fnMfhi) ? dsHi : dsLo;
    end else if (isRType(i, fnJr)) begin
        w.pcWrite = 1'b1;
        w.aluSrcA = srcARegA;
        w.aluOp   = aluPass;
    end else if (isRType(i, fnBreak)) begin
        w.pcWrite = 1'b1;   // pc - 4
        w.aluSrcA = srcAPc;
        w.aluSrcB = srcBFour;
        w.aluOp   = aluSub;
    end else begin
        w.pcWrite     = 1'b1;   // illegal instruction trap
        w.pcSource    = pcFromTrap;
        w.epcWrite    = 1'b1;
        w.excptSelect = excIllegal;
    end
    return w;
endfunction

function automatic ctrlWord_t writeBackWord(instrFields_t i);
    ctrlWord_t w;
    w          = ctrlIdle;
    w.regWrite = 1'b1;
    if (i.opcode == opAddi || i.opcode == opAddiu) begin
        w.regDest = dstRt;
    end else begin
        w.regDest = dstRd;
        if (i.funct != fnAdd && i.funct != fnSub && i.funct != fnAnd) begin
            w.dataSource = dsShift;
        end
    end
    return w;
endfunction

function automatic ctrlWord_t modelWord(instrFields_t i, int idx);
    ctrlWord_t w;
    w = ctrlIdle;
    case (idx)
        0: begin
            w.pcWrite = 1'b1;
            w.aluSrcB = srcBFour;
            w.aluOp   = aluAdd;
        end
        1: w.pcWrite = 1'b1;
        2: w.irWrite = 1'b1;
        3: begin
            w.aWrite      = 1'b1;
            w.bWrite      = 1'b1;
            w.aluOutWrite = 1'b1;
            w.aluSrcB     = srcBOffset;
            w.aluOp       = aluAdd;
        end
        5: w = execWord(i);
        6: begin
            if (modelLength(i) == 8) begin
                w = writeBackWord(i);
            end
        end
        default: w = ctrlIdle;   // dispatch, finish
    endcase
    return w;
endfunction

// File: testbench/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb
    import isaPkg::*, ctrlPkg::*;
;

    localparam int numInstr      = 300;
    localparam int timeoutCycles = numInstr * 8 + 40;

    logic         clk;
    logic         reset;
    instrFields_t instr;
    ctrlWord_t    ctrl;

    logic [31:0] lfsrState;
    int          mismatchCount;
    int          checkCount;
    int          cycleCount;

    `include "controlModel.svh"

    controlUnit controlUnit_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .ctrl  (ctrl)
    );

    bind controlUnit controlUnitChecker ctrlChecker (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic lfsrBit();
        logic b;
        b = lfsrState[0];
        lfsrState = b ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        return b;
    endfunction

    function automatic logic [15:0] randomBits(int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[14:0], lfsrBit()};
        end
        return v;
    endfunction

    function automatic instrFields_t pickInstr();
        instrFields_t i;
        logic [15:0]  sel;
        logic [15:0]  bits;
        logic [funcWidth-1:0] keptFn [13];
        keptFn = '{fnAdd, fnSub, fnAnd, fnSlt, fnSll, fnSrl, fnSra,
                   fnSllv, fnSrav, fnMfhi, fnMflo, fnJr, fnBreak};
        if (randomBits(2) != 2'd0) begin
            sel = randomBits(4) % 15;
            if (sel == 13) begin
                bits = randomBits(funcWidth);
                i    = '{opcode: opAddi, funct: bits[funcWidth-1:0]};
            end else if (sel == 14) begin
                bits = randomBits(funcWidth);
                i    = '{opcode: opAddiu, funct: bits[funcWidth-1:0]};
            end else begin
                i = '{opcode: opRType, funct: keptFn[sel]};
            end
        end else begin
            bits = randomBits(opWidth + funcWidth);
            i    = bits[opWidth+funcWidth-1:0];   // mostly illegal
        end
        return i;
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            mismatchCount++;
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        instrFields_t cur;
        instrFields_t nxt;
        int           len;
        lfsrState     = 32'h38830f88;
        mismatchCount = 0;
        checkCount    = 0;
        cycleCount    = 0;
        reset         = 1'b1;
        instr         = '0;

        repeat (4) begin
            @(negedge clk);
            checkValue("reset stack init", stackInitWord(), ctrl);
        end
        reset = 1'b0;

        cur = pickInstr();
        for (int n = 0; n < numInstr; n++) begin
            len = modelLength(cur);
            nxt = pickInstr();
            for (int idx = 0; idx < len; idx++) begin
                @(negedge clk);
                checkValue($sformatf("instr %0d op %h fn %h step %0d",
                                     n, cur.opcode, cur.funct, idx),
                           modelWord(cur, idx), ctrl);
                if (ctrl.irWrite) begin
                    instr = cur;   // held until the next irWrite
                end
            end
            cur = nxt;
        end

        $display("checks %0d, mismatches %0d", checkCount, mismatchCount);
        if (mismatchCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+testbench
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
testbench/controlUnit_checker.sv
testbench/controlUnitTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module controlUnitTb -f filelist.f \
    && ./obj_dir/VcontrolUnitTb > sim.log 2>&1 \
    ; cat sim.log \
    ; grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
